// ==== logic/lsuPkg.sv ====
package lsuPkg;

    typedef logic [5:0] Tag;
    typedef logic [5:0] SqN;

    typedef enum logic [1:0] {
        AGU_NONE         = 2'd0,
        AGU_MISALIGNED   = 2'd1,
        AGU_ACCESS_FAULT = 2'd2,
        AGU_PAGE_FAULT   = 2'd3
    } AguException;

    typedef enum logic [2:0] {
        FLAGS_NONE            = 3'd0,
        FLAGS_LD_MISALIGNED   = 3'd1,
        FLAGS_LD_ACCESS_FAULT = 3'd2,
        FLAGS_LD_PAGE_FAULT   = 3'd3
    } LoadFlags;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        Tag tagDst;
        SqN sqN;
        logic isMmio;
        AguException exception;
    } LoadReq;

    // data already sits on its byte lanes, wmask marks the written ones
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
        SqN sqN;
        logic isMmio;
    } StoreReq;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchInfo;

    typedef struct packed {
        logic valid;
        Tag tagDst;
        SqN sqN;
        logic [31:0] result;
        LoadFlags flags;
    } LoadResult;

    // enables are active low, addresses count words
    typedef struct packed {
        logic re;
        logic we;
        logic [29:0] raddr;
        logic [29:0] waddr;
        logic [31:0] wdata;
        logic [3:0] wmask;
    } MemReq;

    // sequence numbers wrap, so order is taken from the signed difference
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

// ==== logic/storeQueue.sv ====
module storeQueue import lsuPkg::*; #(
    parameter int SQ_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  StoreReq storeIn,
    input  LoadReq loadIn,
    input  logic stStall,
    output logic storeReady,
    output StoreReq sqHead,
    output logic [3:0] lookupMask,
    output logic [31:0] lookupData
);

    localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    StoreReq entries [SQ_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(SQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign storeReady = (count != CNT_W'(SQ_DEPTH));
    assign push = storeIn.valid && storeReady;
    assign pop = sqHead.valid && !stStall;

    always_comb begin
        sqHead = entries[head];
        sqHead.valid = (count != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= nextPtr(tail);
            end
            if (pop) begin
                head <= nextPtr(head);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= storeIn;
        end
    end

    // walk from the head so that younger stores overwrite older bytes
    always_comb begin
        int idx;
        StoreReq entry;
        lookupMask = '0;
        lookupData = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            idx = (int'(head) + i) % SQ_DEPTH;
            entry = entries[idx];
            if (i < int'(count) && !loadIn.isMmio && !entry.isMmio &&
                    entry.addr[31:2] == loadIn.addr[31:2] &&
                    isYounger(loadIn.sqN, entry.sqN)) begin
                for (int b = 0; b < 4; b++) begin
                    if (entry.wmask[b]) begin
                        lookupMask[b] = 1'b1;
                        lookupData[b*8 +: 8] = entry.data[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== logic/loadStoreUnit.sv ====
module loadStoreUnit import lsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  LoadReq loadIn,
    input  BranchInfo branchIn,
    input  StoreReq sqHead,
    input  logic [3:0] lookupMask,
    input  logic [31:0] lookupData,
    input  logic [31:0] memRdata,
    input  logic [31:0] mmioRdata,
    input  logic mmioWbusy,
    output logic stStall,
    output MemReq memReq,
    output MemReq mmioReq,
    output LoadResult loadOut,
    output logic fwdValid,
    output Tag fwdTag
);

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        Tag tagDst;
        SqN sqN;
        logic isMmio;
        AguException exception;
        logic [3:0] fwdMask;
        logic [31:0] fwdData;
    } Stage;

    Stage stage0;
    Stage stage1;
    logic loadLive;
    logic stage0Live;
    logic fullFwd;
    logic doRead;

    function automatic logic survives(SqN sqN);
        return !(branchIn.taken && isYounger(sqN, branchIn.sqN));
    endfunction

    function automatic Stage toStage(LoadReq req, logic [3:0] mask, logic [31:0] data);
        Stage s;
        s.valid = 1'b1;
        s.addr = req.addr;
        s.size = req.size;
        s.signExtend = req.signExtend;
        s.tagDst = req.tagDst;
        s.sqN = req.sqN;
        s.isMmio = req.isMmio;
        s.exception = req.exception;
        s.fwdMask = mask;
        s.fwdData = data;
        return s;
    endfunction

    function automatic LoadFlags mapFlags(AguException exc);
        case (exc)
            AGU_MISALIGNED: return FLAGS_LD_MISALIGNED;
            AGU_ACCESS_FAULT: return FLAGS_LD_ACCESS_FAULT;
            AGU_PAGE_FAULT: return FLAGS_LD_PAGE_FAULT;
            default: return FLAGS_NONE;
        endcase
    endfunction

    assign loadLive = loadIn.valid && survives(loadIn.sqN);
    assign stage0Live = stage0.valid && survives(stage0.sqN);
    assign fullFwd = (lookupMask == 4'b1111);
    assign doRead = loadLive && !fullFwd;

    assign fwdValid = stage0Live || (loadLive && fullFwd);
    assign fwdTag = stage0Live ? stage0.tagDst : loadIn.tagDst;

    always_comb begin
        memReq.re = 1'b1;
        memReq.we = 1'b1;
        memReq.raddr = loadIn.addr[31:2];
        memReq.waddr = sqHead.addr[31:2];
        memReq.wdata = sqHead.data;
        memReq.wmask = sqHead.wmask;
        mmioReq = memReq;
        stStall = 1'b0;

        if (doRead) begin
            if (loadIn.isMmio) begin
                mmioReq.re = 1'b0;
            end else begin
                memReq.re = 1'b0;
            end
        end

        if (sqHead.valid) begin
            if (sqHead.isMmio) begin
                stStall = mmioWbusy;
                mmioReq.we = mmioWbusy;
            // a RAM read and write to the same word never go out together
            end else if (doRead && !loadIn.isMmio &&
                    loadIn.addr[31:2] == sqHead.addr[31:2]) begin
                stStall = 1'b1;
            end else begin
                memReq.we = 1'b0;
            end
        end
    end

    always_comb begin
        logic [31:0] rdata;
        logic [31:0] merged;
        logic [31:0] result;
        rdata = stage1.isMmio ? mmioRdata : memRdata;
        for (int b = 0; b < 4; b++) begin
            merged[b*8 +: 8] = stage1.fwdMask[b] ? stage1.fwdData[b*8 +: 8] : rdata[b*8 +: 8];
        end

        result = merged;
        case (stage1.size)
            2'd0: begin
                result[7:0] = merged[stage1.addr[1:0]*8 +: 8];
                result[31:8] = {24{stage1.signExtend && result[7]}};
            end
            2'd1: begin
                result[15:0] = stage1.addr[1] ? merged[31:16] : merged[15:0];
                result[31:16] = {16{stage1.signExtend && result[15]}};
            end
            default: result = merged;
        endcase

        loadOut.valid = stage1.valid && survives(stage1.sqN);
        loadOut.tagDst = stage1.tagDst;
        loadOut.sqN = stage1.sqN;
        loadOut.result = result;
        loadOut.flags = mapFlags(stage1.exception);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage0.valid <= 1'b0;
            stage1.valid <= 1'b0;
        end else begin
            stage0.valid <= 1'b0;
            stage1.valid <= 1'b0;
            if (stage0Live) begin
                stage1 <= stage0;
            end
            if (loadLive) begin
                // fully forwarded loads need no memory data and skip stage 0 when it is free
                if (fullFwd && !stage0Live) begin
                    stage1 <= toStage(loadIn, lookupMask, lookupData);
                end else begin
                    stage0 <= toStage(loadIn, lookupMask, lookupData);
                end
            end
        end
    end

endmodule

// ==== logic/dataRam.sv ====
module dataRam import lsuPkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic clk,
    input  MemReq memReq,
    output logic [31:0] rdata
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0] mem [RAM_WORDS];
    logic [AW-1:0] raddrReg;
    logic [AW-1:0] waddr;

    assign waddr = memReq.waddr[AW-1:0];

    always_ff @(posedge clk) begin
        if (!memReq.we) begin
            for (int b = 0; b < 4; b++) begin
                if (memReq.wmask[b]) begin
                    mem[waddr][b*8 +: 8] <= memReq.wdata[b*8 +: 8];
                end
            end
        end
    end

    // address register then output register gives the two-cycle read
    always_ff @(posedge clk) begin
        if (!memReq.re) begin
            raddrReg <= memReq.raddr[AW-1:0];
        end
        rdata <= mem[raddrReg];
    end

endmodule

// ==== logic/mmioRegs.sv ====
module mmioRegs import lsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  MemReq mmioReq,
    output logic [31:0] rdata,
    output logic wbusy
);

    logic [31:0] regs [4];
    logic [1:0] raddrReg;
    logic writeOk;

    assign writeOk = !mmioReq.we && !wbusy;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
            wbusy <= 1'b0;
        end else begin
            // each accepted write blocks the port for one cycle
            wbusy <= writeOk;
            if (writeOk) begin
                for (int b = 0; b < 4; b++) begin
                    if (mmioReq.wmask[b]) begin
                        regs[mmioReq.waddr[1:0]][b*8 +: 8] <= mmioReq.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mmioReq.re) begin
            raddrReg <= mmioReq.raddr[1:0];
        end
        rdata <= regs[raddrReg];
    end

endmodule

// ==== logic/memSubsystem.sv ====
module memSubsystem import lsuPkg::*; #(
    parameter int SQ_DEPTH = 4,
    parameter int RAM_WORDS = 256
) (
    input  logic clk,
    input  logic rst,
    input  LoadReq loadIn,
    input  StoreReq storeIn,
    input  BranchInfo branchIn,
    output logic storeReady,
    output LoadResult loadOut,
    output logic fwdValid,
    output Tag fwdTag
);

    StoreReq sqHead;
    logic stStall;
    logic [3:0] lookupMask;
    logic [31:0] lookupData;
    MemReq memReq;
    MemReq mmioReq;
    logic [31:0] memRdata;
    logic [31:0] mmioRdata;
    logic mmioWbusy;

    storeQueue #(
        .SQ_DEPTH(SQ_DEPTH)
    ) sq0 (
        .clk(clk),
        .rst(rst),
        .storeIn(storeIn),
        .loadIn(loadIn),
        .stStall(stStall),
        .storeReady(storeReady),
        .sqHead(sqHead),
        .lookupMask(lookupMask),
        .lookupData(lookupData)
    );

    loadStoreUnit lsu0 (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .branchIn(branchIn),
        .sqHead(sqHead),
        .lookupMask(lookupMask),
        .lookupData(lookupData),
        .memRdata(memRdata),
        .mmioRdata(mmioRdata),
        .mmioWbusy(mmioWbusy),
        .stStall(stStall),
        .memReq(memReq),
        .mmioReq(mmioReq),
        .loadOut(loadOut),
        .fwdValid(fwdValid),
        .fwdTag(fwdTag)
    );

    dataRam #(
        .RAM_WORDS(RAM_WORDS)
    ) ram0 (
        .clk(clk),
        .memReq(memReq),
        .rdata(memRdata)
    );

    mmioRegs mmio0 (
        .clk(clk),
        .rst(rst),
        .mmioReq(mmioReq),
        .rdata(mmioRdata),
        .wbusy(mmioWbusy)
    );

endmodule

// ==== bench/lsuProps_chk.sv ====
module lsuProps_chk import lsuPkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic clk,
    input  logic rst,
    input  LoadReq loadIn,
    input  StoreReq storeIn,
    input  BranchInfo branchIn,
    input  logic storeReady,
    input  LoadResult loadOut,
    input  logic fwdValid,
    input  Tag fwdTag,
    input  StoreReq sqHead,
    input  logic stStall,
    input  logic mmioWbusy,
    input  MemReq memReq,
    input  MemReq mmioReq
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    typedef struct packed {
        logic valid;
        Tag tagDst;
        SqN sqN;
        logic [31:0] result;
        logic [2:0] flags;
    } Expected;

    // expected results sit in the slot of the cycle they are due, which is at most two ahead
    Expected slots [4];
    logic [3:0] slotLive;
    StoreReq pending [16];
    logic [3:0] qHead;
    logic [4:0] qCount;
    logic [31:0] ramImg [RAM_WORDS];
    logic [31:0] mmioImg [4];
    logic [1:0] cyc;
    logic afterRst = 1'b0;
    int errCount = 0;

    StoreReq front;
    logic handover;
    logic accept;
    logic loadLive;
    logic covered;
    logic stage0Busy;
    logic expFwd;
    Tag expFwdTag;
    Expected due;
    Expected incoming;

    function automatic logic ahead(SqN a, SqN b);
        logic signed [5:0] diff;
        diff = a - b;
        return diff > 6'sd0;
    endfunction

    function automatic logic killedBy(BranchInfo br, SqN s);
        return br.taken && ahead(s, br.sqN);
    endfunction

    function automatic logic [31:0] mergeBytes(logic [31:0] old, logic [31:0] data,
                                               logic [3:0] mask);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] shapeLoad(logic [31:0] word, logic [1:0] off,
                                              logic [1:0] size, logic sx);
        logic [31:0] w;
        w = word >> (5'(off) * 5'd8);
        case (size)
            2'd0: return {{24{sx && w[7]}}, w[7:0]};
            2'd1: return {{16{sx && w[15]}}, w[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [2:0] flagFor(logic [1:0] exc);
        case (exc)
            2'd1: return 3'd1;
            2'd2: return 3'd2;
            2'd3: return 3'd3;
            default: return 3'd0;
        endcase
    endfunction

    always_comb begin
        logic [3:0] fwdMask;
        logic [31:0] word;
        StoreReq e;
        fwdMask = '0;
        front = pending[qHead];
        handover = sqHead.valid && !stStall;
        accept = storeIn.valid && storeReady;
        for (int i = 0; i < 16; i++) begin
            e = pending[4'(qHead + 4'(i))];
            if (5'(i) < qCount && !e.isMmio && !loadIn.isMmio &&
                    e.addr[31:2] == loadIn.addr[31:2] && ahead(loadIn.sqN, e.sqN)) begin
                fwdMask = fwdMask | e.wmask;
            end
        end
        covered = (fwdMask == 4'hf);
        for (int k = 0; k < 4; k++) begin
            slotLive[k] = slots[k].valid && !killedBy(branchIn, slots[k].sqN);
        end
        loadLive = loadIn.valid && !killedBy(branchIn, loadIn.sqN);
        due = slots[cyc];
        due.valid = slotLive[cyc];
        stage0Busy = slotLive[2'(cyc + 2'd1)];
        expFwd = stage0Busy || (loadLive && covered);
        expFwdTag = stage0Busy ? slots[2'(cyc + 2'd1)].tagDst : loadIn.tagDst;

        // MMIO reads see a drain at the same edge but never the queue
        if (loadIn.isMmio) begin
            word = mmioImg[loadIn.addr[3:2]];
            if (handover && front.isMmio && front.addr[3:2] == loadIn.addr[3:2]) begin
                word = mergeBytes(word, front.data, front.wmask);
            end
        end else begin
            word = ramImg[loadIn.addr[2 +: AW]];
        end
        incoming.valid = 1'b1;
        incoming.tagDst = loadIn.tagDst;
        incoming.sqN = loadIn.sqN;
        incoming.result = shapeLoad(word, loadIn.addr[1:0], loadIn.size, loadIn.signExtend);
        incoming.flags = flagFor(loadIn.exception);
    end

    always_ff @(posedge clk) begin
        afterRst <= rst;
        if (rst) begin
            for (int k = 0; k < 4; k++) begin
                slots[k].valid <= 1'b0;
                mmioImg[k] <= '0;
            end
            qHead <= '0;
            qCount <= '0;
            cyc <= '0;
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (!slotLive[k]) begin
                    slots[k].valid <= 1'b0;
                end
            end
            slots[cyc].valid <= 1'b0;
            if (loadLive) begin
                if (covered && !stage0Busy) begin
                    slots[2'(cyc + 2'd1)] <= incoming;
                end else begin
                    slots[2'(cyc + 2'd2)] <= incoming;
                end
            end
            if (handover) begin
                if (front.isMmio) begin
                    mmioImg[front.addr[3:2]] <=
                        mergeBytes(mmioImg[front.addr[3:2]], front.data, front.wmask);
                end
                qHead <= qHead + 4'd1;
            end
            // the RAM image counts a store as soon as it is committed
            if (accept) begin
                pending[4'(qHead + qCount[3:0])] <= storeIn;
                if (!storeIn.isMmio) begin
                    ramImg[storeIn.addr[2 +: AW]] <= mergeBytes(ramImg[storeIn.addr[2 +: AW]],
                                                                storeIn.data, storeIn.wmask);
                end
            end
            qCount <= qCount + 5'(accept) - 5'(handover);
            cyc <= cyc + 2'd1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) loadOut.valid == due.valid)
        else begin
            errCount++;
            $error("[ERROR] loadValid expected %b actual %b", due.valid, loadOut.valid);
        end

    assert property (@(posedge clk) disable iff (rst)
            due.valid |-> loadOut.tagDst == due.tagDst && loadOut.sqN == due.sqN &&
                loadOut.result == due.result)
        else begin
            errCount++;
            $error("[ERROR] loadResult tag %0d sqN %0d expected %h actual %h (tag %0d sqN %0d)",
                   due.tagDst, due.sqN, due.result, loadOut.result, loadOut.tagDst,
                   loadOut.sqN);
        end

    assert property (@(posedge clk) disable iff (rst)
            due.valid |-> 3'(loadOut.flags) == due.flags)
        else begin
            errCount++;
            $error("[ERROR] loadFlags expected %0d actual %0d", due.flags, loadOut.flags);
        end

    assert property (@(posedge clk) disable iff (rst) fwdValid == expFwd)
        else begin
            errCount++;
            $error("[ERROR] fwdValid expected %b actual %b", expFwd, fwdValid);
        end

    assert property (@(posedge clk) disable iff (rst) expFwd |-> fwdTag == expFwdTag)
        else begin
            errCount++;
            $error("[ERROR] fwdTag expected %0d actual %0d", expFwdTag, fwdTag);
        end

    assert property (@(posedge clk) disable iff (rst)
            handover && sqHead.isMmio |-> !mmioWbusy)
        else begin
            errCount++;
            $error("an MMIO store drained while the MMIO port was busy");
        end

    assert property (@(posedge clk) disable iff (rst)
            handover |-> qCount != 5'd0 &&
                {sqHead.addr, sqHead.data, sqHead.wmask, sqHead.sqN, sqHead.isMmio} ==
                {front.addr, front.data, front.wmask, front.sqN, front.isMmio})
        else begin
            errCount++;
            $error("[ERROR] drainOrder expected sqN %0d actual %0d", front.sqN, sqHead.sqN);
        end

    assert property (@(posedge clk)
            afterRst |-> !loadOut.valid && !fwdValid && storeReady && !mmioWbusy &&
                memReq.re && memReq.we && mmioReq.re && mmioReq.we)
        else begin
            errCount++;
            $error("outputs were not idle in the cycle after reset");
        end

endmodule

// ==== bench/lsuTb.sv ====
module lsuTb import lsuPkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS = 400;
    localparam int INIT_WORDS = 16;
    localparam int PERIOD = 100;

    logic clk;
    logic rst;
    LoadReq loadIn;
    StoreReq storeIn;
    BranchInfo branchIn;
    logic storeReady;
    LoadResult loadOut;
    logic fwdValid;
    Tag fwdTag;

    logic [15:0] lfsr = 16'd41173;
    SqN nextSqN;
    Tag nextTag;

    memSubsystem #(
        .RAM_WORDS(16)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .storeIn(storeIn),
        .branchIn(branchIn),
        .storeReady(storeReady),
        .loadOut(loadOut),
        .fwdValid(fwdValid),
        .fwdTag(fwdTag)
    );

    bind memSubsystem lsuProps_chk #(
        .RAM_WORDS(RAM_WORDS)
    ) props0 (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .storeIn(storeIn),
        .branchIn(branchIn),
        .storeReady(storeReady),
        .loadOut(loadOut),
        .fwdValid(fwdValid),
        .fwdTag(fwdTag),
        .sqHead(sqHead),
        .stStall(stStall),
        .mmioWbusy(mmioWbusy),
        .memReq(memReq),
        .mmioReq(mmioReq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Galois form, one step per bit handed out
    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic clearInputs();
        loadIn.valid = 1'b0;
        storeIn.valid = 1'b0;
        branchIn.taken = 1'b0;
    endtask

    // size and an offset aligned to it
    task automatic pickShape(output logic [1:0] size, output logic [1:0] off);
        logic [31:0] r;
        takeBits(2, r);
        size = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
        takeBits(2, r);
        off = (size == 2'd0) ? r[1:0] : (size == 2'd1) ? {r[0], 1'b0} : 2'd0;
    endtask

    task automatic sendStore(input logic isMmio, input logic [3:0] word,
                             input logic [1:0] size, input logic [1:0] off);
        logic [31:0] data;
        takeBits(32, data);
        @(negedge clk);
        clearInputs();
        storeIn.valid = 1'b1;
        storeIn.addr = {26'd0, word, off};
        storeIn.data = data;
        storeIn.wmask = (size == 2'd0) ? (4'b0001 << off) :
                        (size == 2'd1) ? (4'b0011 << off) : 4'b1111;
        storeIn.sqN = nextSqN;
        storeIn.isMmio = isMmio;
        while (!storeReady) begin
            @(negedge clk);
        end
        nextSqN = nextSqN + 6'd1;
    endtask

    task automatic sendLoad(input logic isMmio, input logic [3:0] word);
        logic [31:0] r;
        logic [1:0] size;
        logic [1:0] off;
        pickShape(size, off);
        takeBits(3, r);
        @(negedge clk);
        clearInputs();
        loadIn.valid = 1'b1;
        loadIn.addr = {26'd0, word, off};
        loadIn.size = size;
        loadIn.signExtend = r[2];
        loadIn.tagDst = nextTag;
        loadIn.sqN = nextSqN;
        loadIn.isMmio = isMmio;
        loadIn.exception = AguException'(r[1:0]);
        nextTag = nextTag + 6'd1;
    endtask

    task automatic sendBranch();
        logic [31:0] r;
        takeBits(1, r);
        @(negedge clk);
        clearInputs();
        branchIn.taken = 1'b1;
        branchIn.sqN = nextSqN - 6'd1 - 6'(r[0]);
    endtask

    initial begin
        #((NUM_OPS + INIT_WORDS) * 10 * PERIOD);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired before the operations completed");
    end

    always @(negedge clk) begin
        if (dut0.props0.errCount != 0) begin
            $display("CHECKS FAILED");
            $fatal(1, "an assertion in the bound checker failed");
        end
    end

    initial begin
        logic [31:0] r;
        logic [1:0] size;
        logic [1:0] off;
        rst = 1'b1;
        loadIn = '0;
        storeIn = '0;
        branchIn = '0;
        nextSqN = '0;
        nextTag = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // every RAM word gets a known value before any load
        for (int w = 0; w < INIT_WORDS; w++) begin
            sendStore(1'b0, 4'(w), 2'd2, 2'd0);
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            takeBits(3, r);
            case (r[2:0])
                3'd0, 3'd1, 3'd2: begin
                    pickShape(size, off);
                    takeBits(5, r);
                    sendStore(r[4], r[4] ? {2'b00, r[1:0]} : r[3:0], size, off);
                end
                3'd3, 3'd4: begin
                    takeBits(4, r);
                    sendLoad(1'b0, r[3:0]);
                end
                3'd5: begin
                    takeBits(2, r);
                    sendLoad(1'b1, {2'b00, r[1:0]});
                end
                3'd6: begin
                    takeBits(4, r);
                    sendStore(1'b0, r[3:0], 2'd2, 2'd0);
                    sendLoad(1'b0, r[3:0]);
                end
                default: begin
                    sendBranch();
                end
            endcase
        end

        @(negedge clk);
        clearInputs();
        repeat (4) @(negedge clk);
        if (dut0.props0.errCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures were counted");
        end
    end

endmodule

// ==== vlog.f ====
logic/lsuPkg.sv
logic/storeQueue.sv
logic/loadStoreUnit.sv
logic/dataRam.sv
logic/mmioRegs.sv
logic/memSubsystem.sv
bench/lsuProps_chk.sv
bench/lsuTb.sv

// ==== runSim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the simulator's

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module lsuTb -f vlog.f -o lsuSim; then
    echo "build failed"
    exit 1
fi

./obj_dir/lsuSim +verilator+error+limit+1000
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0
